// ==== hw/fft_pkg.sv ====
`default_nettype none

package fft_pkg;

   // Pipeline depths that the stages rely on to line up the sync strobe
   localparam int WM_LATENCY  = 4;  // Twiddle multiplier, input to output
   localparam int ROM_LATENCY = 1;  // Twiddle ROM read

   localparam int DEF_WIDTH         = 16;
   localparam int DEF_TWIDDLE_WIDTH = 10;

   // Outputs leave the SDF chain in bit-reversed order, so ctr_o maps to
   // a bin number by reversing its low bits
   function automatic int unsigned bit_reverse(input int unsigned idx,
                                               input int unsigned bits);
      int unsigned r;
      r = 0;
      for (int unsigned b = 0; b < bits; b++) begin
         r = (r << 1) | ((idx >> b) & 1);
      end
      return r;
   endfunction

endpackage

`default_nettype wire

// ==== hw/fft_twiddle_rom.sv ====
`timescale 1ns/1ns
`default_nettype none

module fft_twiddle_rom #(
   parameter int TWIDDLE_WIDTH = fft_pkg::DEF_TWIDDLE_WIDTH,
   parameter int N             = 16,
   parameter int STAGE         = 0
) (
   input  wire logic                            clk,
   input  wire logic [$clog2(N)-1:0]            ctr_i,
   output logic signed [TWIDDLE_WIDTH-1:0]      w_re_o,
   output logic signed [TWIDDLE_WIDTH-1:0]      w_im_o
);

   localparam int LOG2N = $clog2(N);
   localparam int D     = N >> (STAGE + 1);
   localparam int PB    = LOG2N - 1 - STAGE;  // Phase bit of ctr_i
   localparam int LAT   = fft_pkg::ROM_LATENCY;

   // Twiddle W_N^k scaled so that 1.0 maps to the largest positive code
   function automatic logic signed [TWIDDLE_WIDTH-1:0] tw_val(input int k, input bit im);
      real ang;
      real v;
      int  iv;
      ang = 2.0 * 3.14159265358979 * k / N;
      v   = im ? -$sin(ang) : $cos(ang);
      iv  = int'(v * ((1 << (TWIDDLE_WIDTH - 1)) - 1));  // Cast rounds to nearest
      return iv[TWIDDLE_WIDTH-1:0];
   endfunction

   logic signed [TWIDDLE_WIDTH-1:0] rom_re [0:D-1];
   logic signed [TWIDDLE_WIDTH-1:0] rom_im [0:D-1];
   logic signed [TWIDDLE_WIDTH-1:0] w_re_sr [0:LAT-1];
   logic signed [TWIDDLE_WIDTH-1:0] w_im_sr [0:LAT-1];
   logic [PB-1:0]                   idx;

   // Only the k = j * 2^STAGE subset is ever needed by this stage
   for (genvar j = 0; j < D; j++) begin : g_tab
      localparam logic signed [TWIDDLE_WIDTH-1:0] RE = tw_val(j << STAGE, 1'b0);
      localparam logic signed [TWIDDLE_WIDTH-1:0] IM = tw_val(j << STAGE, 1'b1);
      assign rom_re[j] = RE;
      assign rom_im[j] = IM;
   end

   // Entry 0 holds the unit twiddle used while the butterfly emits sums
   assign idx = ctr_i[PB] ? ctr_i[PB-1:0] : '0;

   always_ff @(posedge clk) begin
      w_re_sr[0] <= rom_re[idx];
      w_im_sr[0] <= rom_im[idx];
      for (int i = 1; i < LAT; i++) begin
         w_re_sr[i] <= w_re_sr[i-1];
         w_im_sr[i] <= w_im_sr[i-1];
      end
   end

   assign w_re_o = w_re_sr[LAT-1];
   assign w_im_o = w_im_sr[LAT-1];

endmodule

`default_nettype wire

// ==== hw/fft_bf.sv ====
`timescale 1ns/1ns
`default_nettype none

module fft_bf #(
   parameter int WIDTH = fft_pkg::DEF_WIDTH,
   parameter int N     = 16,
   parameter int STAGE = 0
) (
   input  wire logic                       clk,
   input  wire logic                       srst_n,
   input  wire logic signed [WIDTH-1:0]    x_re_i,
   input  wire logic signed [WIDTH-1:0]    x_im_i,
   input  wire logic [$clog2(N)-1:0]       ctr_i,
   input  wire logic                       sync_i,
   output logic signed [WIDTH-1:0]         z_re_o,
   output logic signed [WIDTH-1:0]         z_im_o,
   output logic [$clog2(N)-1:0]            ctr_o,
   output logic                            sync_o
);

   localparam int LOG2N = $clog2(N);
   localparam int D     = N >> (STAGE + 1);  // Feedback delay depth
   localparam int PB    = LOG2N - 1 - STAGE;

   logic signed [WIDTH-1:0] dl_re [0:D-1];
   logic signed [WIDTH-1:0] dl_im [0:D-1];
   logic signed [WIDTH-1:0] old_re;
   logic signed [WIDTH-1:0] old_im;
   logic signed [WIDTH:0]   sum_re;
   logic signed [WIDTH:0]   sum_im;
   logic signed [WIDTH:0]   dif_re;
   logic signed [WIDTH:0]   dif_im;
   logic [LOG2N-1:0]        ctr_sr [0:D];
   logic [D:0]              sync_sr;
   logic                    phase;

   // Divide by two with round half to even; the sum of two WIDTH-bit words
   // halved always fits back into WIDTH bits
   function automatic logic signed [WIDTH-1:0] half_round(input logic signed [WIDTH:0] v);
      logic [WIDTH:0] q;
      q = {v[WIDTH], v[WIDTH:1]} + (v[0] & v[1]);
      return q[WIDTH-1:0];
   endfunction

   assign phase  = ctr_i[PB];       // Low half loads, high half computes
   assign old_re = dl_re[D-1];      // Sample from D cycles earlier
   assign old_im = dl_im[D-1];

   assign sum_re = old_re + x_re_i;
   assign sum_im = old_im + x_im_i;
   assign dif_re = old_re - x_re_i;
   assign dif_im = old_im - x_im_i;

   always_ff @(posedge clk) begin
      // The delay line takes raw input in the load half and feeds the
      // differences back in the compute half
      dl_re[0] <= phase ? half_round(dif_re) : x_re_i;
      dl_im[0] <= phase ? half_round(dif_im) : x_im_i;
      for (int i = 1; i < D; i++) begin
         dl_re[i] <= dl_re[i-1];
         dl_im[i] <= dl_im[i-1];
      end

      // In the load half the stored differences drain out
      if (phase) begin
         z_re_o <= half_round(sum_re);
         z_im_o <= half_round(sum_im);
      end else begin
         z_re_o <= old_re;
         z_im_o <= old_im;
      end
   end

   // Index travels D+1 cycles so each output keeps its own position
   always_ff @(posedge clk) begin
      ctr_sr[0] <= ctr_i;
      for (int i = 1; i <= D; i++) begin
         ctr_sr[i] <= ctr_sr[i-1];
      end
   end

   always_ff @(posedge clk) begin
      if (!srst_n) begin
         sync_sr <= '0;
      end else begin
         sync_sr <= {sync_sr[D-1:0], sync_i};
      end
   end

   assign ctr_o  = ctr_sr[D];
   assign sync_o = sync_sr[D];

endmodule

`default_nettype wire

// ==== hw/fft_wm.sv ====
`timescale 1ns/1ns
`default_nettype none

module fft_wm #(
   parameter int WIDTH         = fft_pkg::DEF_WIDTH,
   parameter int TWIDDLE_WIDTH = fft_pkg::DEF_TWIDDLE_WIDTH,
   parameter int N             = 16
) (
   input  wire logic                              clk,
   input  wire logic                              srst_n,
   input  wire logic                              carry_in,
   output logic                                   carry_out,
   input  wire logic [$clog2(N)-1:0]              ctr_i,
   output logic [$clog2(N)-1:0]                   ctr_o,
   input  wire logic signed [WIDTH-1:0]           x_re_i,
   input  wire logic signed [WIDTH-1:0]           x_im_i,
   input  wire logic signed [TWIDDLE_WIDTH-1:0]   w_re_i,
   input  wire logic signed [TWIDDLE_WIDTH-1:0]   w_im_i,
   output logic signed [WIDTH-1:0]                z_re_o,
   output logic signed [WIDTH-1:0]                z_im_o
);

   localparam int LAT = fft_pkg::WM_LATENCY;
   localparam int CW  = $clog2(N);
   localparam int PW  = WIDTH + TWIDDLE_WIDTH + 1;  // Product width with headroom

   logic signed [WIDTH-1:0]         x1_re;
   logic signed [WIDTH-1:0]         x1_im;
   logic signed [TWIDDLE_WIDTH-1:0] w1_re;
   logic signed [TWIDDLE_WIDTH-1:0] w1_im;
   logic signed [WIDTH-1:0]         x2_re;
   logic signed [WIDTH-1:0]         x2_im;
   logic signed [TWIDDLE_WIDTH:0]   wd;
   logic signed [TWIDDLE_WIDTH:0]   ws;
   logic signed [PW-1:0]            kar_f;
   logic signed [PW-1:0]            kar_r;
   logic signed [PW-1:0]            kar_i;
   logic [CW-1:0]                   ctr_sr [0:LAT-1];
   logic [LAT-1:0]                  carry_sr;

   // Convergent rounding at the twiddle LSB position, then keep WIDTH bits.
   // The top bit is redundant as no twiddle exceeds 2^(TWIDDLE_WIDTH-1)
   function automatic logic signed [WIDTH-1:0] round_out(input logic signed [PW-1:0] v);
      logic [PW-1:0] r;
      r = v + {{(PW-TWIDDLE_WIDTH+1){1'b0}}, v[TWIDDLE_WIDTH-1],
               {(TWIDDLE_WIDTH-2){~v[TWIDDLE_WIDTH-1]}}};
      return r[WIDTH+TWIDDLE_WIDTH-2:TWIDDLE_WIDTH-1];
   endfunction

   // (a+jb)(c+jd) with f = c(a-b), R = b(c-d) + f, I = a(c+d) - f
   always_ff @(posedge clk) begin
      x1_re <= x_re_i;
      x1_im <= x_im_i;
      w1_re <= w_re_i;
      w1_im <= w_im_i;

      kar_f <= w1_re * (x1_re - x1_im);  // First multiply
      x2_re <= x1_re;
      x2_im <= x1_im;
      wd    <= w1_re - w1_im;
      ws    <= w1_re + w1_im;

      kar_r <= x2_im * wd + kar_f;  // Remaining two share this cycle
      kar_i <= x2_re * ws - kar_f;

      z_re_o <= round_out(kar_r);
      z_im_o <= round_out(kar_i);
   end

   always_ff @(posedge clk) begin
      ctr_sr[0] <= ctr_i;
      for (int i = 1; i < LAT; i++) begin
         ctr_sr[i] <= ctr_sr[i-1];
      end
   end

   always_ff @(posedge clk) begin
      if (!srst_n) begin
         carry_sr <= '0;
      end else begin
         carry_sr <= {carry_sr[LAT-2:0], carry_in};
      end
   end

   assign ctr_o     = ctr_sr[LAT-1];
   assign carry_out = carry_sr[LAT-1];

   // The strobe must come out with the product it entered with
   a_carry_latency: assert property (@(posedge clk) disable iff (!srst_n)
      $past(srst_n, LAT) |-> carry_out == $past(carry_in, LAT));

endmodule

`default_nettype wire

// ==== hw/fft_stage.sv ====
`timescale 1ns/1ns
`default_nettype none

module fft_stage #(
   parameter int WIDTH         = fft_pkg::DEF_WIDTH,
   parameter int TWIDDLE_WIDTH = fft_pkg::DEF_TWIDDLE_WIDTH,
   parameter int N             = 16,
   parameter int STAGE         = 0
) (
   input  wire logic                       clk,
   input  wire logic                       srst_n,
   input  wire logic signed [WIDTH-1:0]    x_re_i,
   input  wire logic signed [WIDTH-1:0]    x_im_i,
   input  wire logic [$clog2(N)-1:0]       ctr_i,
   input  wire logic                       sync_i,
   output logic signed [WIDTH-1:0]         z_re_o,
   output logic signed [WIDTH-1:0]         z_im_o,
   output logic [$clog2(N)-1:0]            ctr_o,
   output logic                            sync_o
);

   localparam int LOG2N = $clog2(N);
   localparam int RL    = fft_pkg::ROM_LATENCY;
   localparam bit LAST  = (STAGE == LOG2N - 1);

   if (LAST) begin : g_last
      // No twiddle after the final butterfly
      fft_bf #(.WIDTH(WIDTH), .N(N), .STAGE(STAGE)) fft_bf_inst (
         .clk(clk), .srst_n(srst_n),
         .x_re_i(x_re_i), .x_im_i(x_im_i), .ctr_i(ctr_i), .sync_i(sync_i),
         .z_re_o(z_re_o), .z_im_o(z_im_o), .ctr_o(ctr_o), .sync_o(sync_o)
      );
   end else begin : g_tw
      logic signed [WIDTH-1:0]         bf_re;
      logic signed [WIDTH-1:0]         bf_im;
      logic [LOG2N-1:0]                bf_ctr;
      logic                            bf_sync;
      logic signed [TWIDDLE_WIDTH-1:0] w_re;
      logic signed [TWIDDLE_WIDTH-1:0] w_im;
      logic signed [WIDTH-1:0]         al_re [0:RL-1];
      logic signed [WIDTH-1:0]         al_im [0:RL-1];
      logic [LOG2N-1:0]                al_ctr [0:RL-1];
      logic                            al_sync [0:RL-1];

      fft_bf #(.WIDTH(WIDTH), .N(N), .STAGE(STAGE)) fft_bf_inst (
         .clk(clk), .srst_n(srst_n),
         .x_re_i(x_re_i), .x_im_i(x_im_i), .ctr_i(ctr_i), .sync_i(sync_i),
         .z_re_o(bf_re), .z_im_o(bf_im), .ctr_o(bf_ctr), .sync_o(bf_sync)
      );

      fft_twiddle_rom #(
         .TWIDDLE_WIDTH(TWIDDLE_WIDTH), .N(N), .STAGE(STAGE)
      ) fft_twiddle_rom_inst (
         .clk(clk), .ctr_i(bf_ctr), .w_re_o(w_re), .w_im_o(w_im)
      );

      // Hold the butterfly output while the ROM looks up its twiddle
      always_ff @(posedge clk) begin
         al_re[0]  <= bf_re;
         al_im[0]  <= bf_im;
         al_ctr[0] <= bf_ctr;
         for (int i = 1; i < RL; i++) begin
            al_re[i]  <= al_re[i-1];
            al_im[i]  <= al_im[i-1];
            al_ctr[i] <= al_ctr[i-1];
         end
      end

      always_ff @(posedge clk) begin
         if (!srst_n) begin
            for (int i = 0; i < RL; i++) al_sync[i] <= 1'b0;
         end else begin
            al_sync[0] <= bf_sync;
            for (int i = 1; i < RL; i++) al_sync[i] <= al_sync[i-1];
         end
      end

      fft_wm #(.WIDTH(WIDTH), .TWIDDLE_WIDTH(TWIDDLE_WIDTH), .N(N)) fft_wm_inst (
         .clk(clk), .srst_n(srst_n),
         .carry_in(al_sync[RL-1]), .carry_out(sync_o),
         .ctr_i(al_ctr[RL-1]), .ctr_o(ctr_o),
         .x_re_i(al_re[RL-1]), .x_im_i(al_im[RL-1]),
         .w_re_i(w_re), .w_im_i(w_im),
         .z_re_o(z_re_o), .z_im_o(z_im_o)
      );
   end

endmodule

`default_nettype wire

// ==== hw/fft_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module fft_top #(
   parameter int WIDTH         = fft_pkg::DEF_WIDTH,
   parameter int TWIDDLE_WIDTH = fft_pkg::DEF_TWIDDLE_WIDTH,
   parameter int N             = 16
) (
   input  wire logic                       clk,
   input  wire logic                       srst_n,
   input  wire logic                       sync_i,
   input  wire logic signed [WIDTH-1:0]    x_re_i,
   input  wire logic signed [WIDTH-1:0]    x_im_i,
   output logic signed [WIDTH-1:0]         z_re_o,
   output logic signed [WIDTH-1:0]         z_im_o,
   output logic [$clog2(N)-1:0]            ctr_o,
   output logic                            sync_o
);

   localparam int LOG2N = $clog2(N);

   logic signed [WIDTH-1:0] in_re;
   logic signed [WIDTH-1:0] in_im;
   logic [LOG2N-1:0]        ctr_q;
   logic                    sync_q;
   logic                    started;  // Set by the first frame after reset
   logic signed [WIDTH-1:0] s_re [0:LOG2N];
   logic signed [WIDTH-1:0] s_im [0:LOG2N];
   logic [LOG2N-1:0]        s_ctr [0:LOG2N];
   logic [LOG2N:0]          s_sync;

   always_ff @(posedge clk) begin
      in_re <= x_re_i;
      in_im <= x_im_i;
   end

   // Index of the registered sample; wraps modulo N by width alone
   always_ff @(posedge clk) begin
      if (!srst_n) begin
         ctr_q   <= '0;
         sync_q  <= 1'b0;
         started <= 1'b0;
      end else begin
         ctr_q   <= sync_i ? '0 : ctr_q + 1'b1;
         sync_q  <= sync_i;
         started <= started | sync_i;
      end
   end

   assign s_re[0]   = in_re;
   assign s_im[0]   = in_im;
   assign s_ctr[0]  = ctr_q;
   assign s_sync[0] = sync_q;

   for (genvar s = 0; s < LOG2N; s++) begin : g_stage
      fft_stage #(.WIDTH(WIDTH), .TWIDDLE_WIDTH(TWIDDLE_WIDTH), .N(N), .STAGE(s)) fft_stage_inst (
         .clk(clk), .srst_n(srst_n),
         .x_re_i(s_re[s]), .x_im_i(s_im[s]), .ctr_i(s_ctr[s]), .sync_i(s_sync[s]),
         .z_re_o(s_re[s+1]), .z_im_o(s_im[s+1]), .ctr_o(s_ctr[s+1]), .sync_o(s_sync[s+1])
      );
   end

   assign z_re_o = s_re[LOG2N];
   assign z_im_o = s_im[LOG2N];
   assign ctr_o  = s_ctr[LOG2N];
   assign sync_o = s_sync[LOG2N];

   // Frames are gapless, so a new frame may only start right after a full one
   a_sync_on_wrap: assert property (@(posedge clk) disable iff (!srst_n)
      sync_i |-> (!started || ctr_q == N - 1));

endmodule

`default_nettype wire

// ==== bench/fft_clk_gen.sv ====
`timescale 1ns/1ns
`default_nettype none

module fft_clk_gen #(
   parameter int PERIOD     = 20,
   parameter int RST_CYCLES = 16
) (
   output logic clk_o,
   output logic srst_n_o
);

   initial begin
      clk_o = 1'b0;
      forever #(PERIOD / 2) clk_o = ~clk_o;
   end

   // Reset is released on a rising edge so it behaves as a synchronous input
   initial begin
      srst_n_o = 1'b0;
      repeat (RST_CYCLES) @(posedge clk_o);
      srst_n_o <= 1'b1;
   end

endmodule

`default_nettype wire

// ==== bench/fft_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module fft_tb;

   localparam int  N         = 16;
   localparam int  LOG2N     = $clog2(N);
   localparam int  WIDTH     = fft_pkg::DEF_WIDTH;
   localparam int  TW        = fft_pkg::DEF_TWIDDLE_WIDTH;
   localparam int  NF        = 6;  // Impulse, dc, tone, then three random frames
   localparam int  NT        = 5;
   localparam int  RND_LIM   = 1 << (WIDTH - 2);
   localparam int  WD_CYCLES = (NF + 4) * N * 4 + 100;
   localparam real PI        = 3.14159265358979;

   logic                    clk;
   logic                    srst_n;
   logic                    sync_i;
   logic signed [WIDTH-1:0] x_re;
   logic signed [WIDTH-1:0] x_im;
   logic signed [WIDTH-1:0] z_re;
   logic signed [WIDTH-1:0] z_im;
   logic [LOG2N-1:0]        ctr_o;
   logic                    sync_o;

   int     stim_re [0:NF*N-1];
   int     stim_im [0:NF*N-1];
   int     test_errs [0:NT-1];
   string  test_names [0:NT-1];
   int     checks;
   bit     first_frame_sent;
   bit     cmp_done;
   integer seed;

   fft_clk_gen #(.PERIOD(20), .RST_CYCLES(16)) fft_clk_gen_inst (
      .clk_o(clk), .srst_n_o(srst_n)
   );

   fft_top #(.WIDTH(WIDTH), .TWIDDLE_WIDTH(TW), .N(N)) fft_top_inst (
      .clk(clk), .srst_n(srst_n), .sync_i(sync_i), .x_re_i(x_re), .x_im_i(x_im),
      .z_re_o(z_re), .z_im_o(z_im), .ctr_o(ctr_o), .sync_o(sync_o)
   );

   // X[k] = (1/N) sum of x[n] e^(-j 2 pi n k / N) over frame f
   function automatic void ref_dft(input int f, input int k, output real re, output real im);
      real ang;
      re = 0.0;
      im = 0.0;
      for (int n = 0; n < N; n++) begin
         ang = -2.0 * PI * n * k / N;
         re += stim_re[f*N+n] * $cos(ang) - stim_im[f*N+n] * $sin(ang);
         im += stim_re[f*N+n] * $sin(ang) + stim_im[f*N+n] * $cos(ang);
      end
      re = re / N;
      im = im / N;
   endfunction

   // Unit twiddle is stored as 2^(TW-1)-1 and scaled back by 2^(TW-1) in each twiddled stage
   function automatic real twiddle_gain();
      real g;
      g = 1.0;
      for (int s = 0; s < LOG2N - 1; s++) begin
         g = g * ((1 << (TW - 1)) - 1) / real'(1 << (TW - 1));
      end
      return g;
   endfunction

   // Half an LSB of rounding per operation, plus the twiddle quantization error
   // of each twiddled stage, which grows with the largest sample in the frame
   function automatic real frame_tol(input int f);
      int peak;
      peak = 0;
      for (int n = 0; n < N; n++) begin
         if (stim_re[f*N+n] > peak || -stim_re[f*N+n] > peak) peak = abs_int(stim_re[f*N+n]);
         if (stim_im[f*N+n] > peak || -stim_im[f*N+n] > peak) peak = abs_int(stim_im[f*N+n]);
      end
      return LOG2N + 1 + (LOG2N - 1) * peak / real'(1 << (TW - 1));
   endfunction

   function automatic int abs_int(input int v);
      return (v < 0) ? -v : v;
   endfunction

   function automatic int test_of(input int f);
      return (f < 3) ? f : 3;  // All random frames count as one test
   endfunction

   task automatic build_frames();
      real ang;
      for (int n = 0; n < N; n++) begin
         ang = 2.0 * PI * 3 * n / N;
         stim_re[n]     = (n == 0) ? 16384 : 0;
         stim_im[n]     = 0;
         stim_re[N+n]   = 3000;
         stim_im[N+n]   = -1200;
         stim_re[2*N+n] = int'(8192.0 * $cos(ang));  // Tone at bin 3
         stim_im[2*N+n] = int'(8192.0 * $sin(ang));
      end
      for (int i = 3 * N; i < NF * N; i++) begin
         stim_re[i] = $random(seed) % (RND_LIM + 1);
         stim_im[i] = $random(seed) % (RND_LIM + 1);
      end
   endtask

   task automatic check_part(input int f, input int bin, input string part,
                             input real expected, input int actual, input real tol);
      real d;
      d = actual - expected;
      checks++;
      assert (d <= tol && d >= -tol) else begin
         $display("** Error %s bin %0d %s: expected %0.1f actual %0d",
                  test_names[test_of(f)], bin, part, expected, actual);
         test_errs[test_of(f)]++;
      end
   endtask

   task automatic report_test(input int t);
      if (test_errs[t] == 0) begin
         $display("%s: passed", test_names[t]);
      end else begin
         $display("%s: failed with %0d errors", test_names[t], test_errs[t]);
      end
   endtask

   // Stimulus, frames back to back with sync_i on each first sample
   initial begin
      seed             = 73987;
      sync_i           = 1'b0;
      x_re             = '0;
      x_im             = '0;
      first_frame_sent = 1'b0;
      build_frames();
      wait (srst_n === 1'b1);
      repeat (4) @(posedge clk);
      for (int f = 0; f < NF; f++) begin
         for (int n = 0; n < N; n++) begin
            sync_i <= (n == 0);
            x_re   <= stim_re[f*N+n];
            x_im   <= stim_im[f*N+n];
            @(posedge clk);
         end
         first_frame_sent = 1'b1;
      end
      sync_i <= 1'b0;  // Zeros keep the pipeline draining
      x_re   <= '0;
      x_im   <= '0;
   end

   // sync_o must stay low through reset and until a whole frame has entered
   initial begin
      @(posedge clk);
      while (!first_frame_sent) begin
         @(negedge clk);
         assert (sync_o === 1'b0) else begin
            $display("sync_o pulsed before the first frame had entered the FFT");
            test_errs[4]++;
         end
      end
   end

   // Compare process, sampling on the falling edge where outputs are settled
   initial begin
      bit [N-1:0] seen;
      int         bin;
      real        tol;
      real        gain;
      real        e_re;
      real        e_im;
      test_names[0] = "impulse";
      test_names[1] = "dc";
      test_names[2] = "tone";
      test_names[3] = "random";
      test_names[4] = "sync_reset";
      for (int t = 0; t < NT; t++) test_errs[t] = 0;
      checks   = 0;
      cmp_done = 1'b0;
      gain     = twiddle_gain();
      for (int f = 0; f < NF; f++) begin
         @(negedge clk);
         while (sync_o !== 1'b1) @(negedge clk);
         seen = '0;
         tol  = frame_tol(f);
         for (int n = 0; n < N; n++) begin
            if (n > 0) begin
               @(negedge clk);
               assert (sync_o === 1'b0) else begin
                  $display("sync_o pulsed in the middle of output frame %0d", f);
                  test_errs[4]++;
               end
            end
            bin = fft_pkg::bit_reverse(ctr_o, LOG2N);
            assert (seen[ctr_o] == 1'b0) else begin
               $display("ctr_o value %0d appeared twice in output frame %0d", ctr_o, f);
               test_errs[4]++;
            end
            seen[ctr_o] = 1'b1;
            ref_dft(f, bin, e_re, e_im);
            check_part(f, bin, "re", gain * e_re, z_re, tol);
            check_part(f, bin, "im", gain * e_im, z_im, tol);
         end
         if (f < 3 || f == NF - 1) report_test(test_of(f));
      end
      cmp_done = 1'b1;
   end

   initial begin
      int failed;
      wait (cmp_done);
      report_test(4);
      failed = 0;
      for (int t = 0; t < NT; t++) begin
         if (test_errs[t] != 0) failed++;
      end
      $display("Summary: %0d tests, %0d passed, %0d failed, %0d value checks",
               NT, NT - failed, failed, checks);
      if (failed == 0) begin
         $display("STATUS: PASS");
      end else begin
         $display("STATUS: FAIL");
      end
      $finish;
   end

   // Watchdog, generous against reset, all frames and the pipeline latency
   initial begin
      repeat (WD_CYCLES) @(posedge clk);
      $display("Timeout after %0d cycles: sync_o never arrived for all %0d frames",
               WD_CYCLES, NF);
      $display("STATUS: FAIL");
      $finish;
   end

endmodule

`default_nettype wire

// ==== build.f ====
hw/fft_pkg.sv
hw/fft_twiddle_rom.sv
hw/fft_bf.sv
hw/fft_wm.sv
hw/fft_stage.sv
hw/fft_top.sv
bench/fft_clk_gen.sv
bench/fft_tb.sv
